/* Makefile */
# Verilator build and run of the SHA-256 hasher testbench

SIM := obj_dir/Vtb_sha256

$(SIM): build.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_sha256 -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* build.f */
sha256_pkg.sv
msg_pkg.sv
msg_padder.sv
word_fifo.sv
sha256_core.sv
sha256_top.sv
sha256_checker.sv
sha256_assert.sv
tb_sha256.sv

/* msg_padder.sv */
// SHA-256 message padder
// Packs a byte stream into big-endian 32-bit words and appends
// the 0x80 marker, the zero fill and the 64-bit bit length

`timescale 1ns/1ps

module msg_padder
    import msg_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [byte_w-1:0]     byte_data_i,
    input  logic                  byte_last_i,
    input  logic                  byte_empty_i,
    input  logic                  byte_valid_i,
    output logic                  byte_ready_o,
    output logic [4*byte_w-1:0]   word_data_o,
    output logic                  word_last_o,
    output logic                  word_valid_o,
    input  logic                  word_ready_i
);

    localparam int word_bits = 4 * byte_w;
    localparam logic [byte_w-1:0] pad_mark = {1'b1, {(byte_w-1){1'b0}}};

    pad_state_t             state;
    logic [word_bits-1:0]   acc;         // bytes of the current word
    logic [1:0]             byte_idx;
    logic [3:0]             word_idx;    // word position in the block
    logic [len_w-1:0]       msg_len;
    logic [2*word_bits-1:0] bit_len;
    logic [word_bits-1:0]   mark_word;
    logic [word_bits-1:0]   next_word;
    logic                   next_last;
    logic                   load_word;
    logic                   out_free;
    logic                   byte_fire;
    logic                   data_fire;

    assign out_free     = !word_valid_o || word_ready_i;
    assign byte_ready_o = (state == DATA) && out_free;
    assign byte_fire    = byte_valid_i && byte_ready_o;
    assign data_fire    = byte_fire && !byte_empty_i;

    assign bit_len   = {{(2*word_bits-len_w){1'b0}}, msg_len} << 3;
    // partial bytes move to the top, marker follows, rest zero
    assign mark_word = {acc[word_bits-byte_w-1:0], pad_mark} << (byte_w * (3 - byte_idx));

    always_comb begin
        load_word = 1'b0;
        next_word = '0;
        next_last = 1'b0;
        case (state)
            DATA: begin
                load_word = data_fire && (byte_idx == 2'd3);
                next_word = {acc[word_bits-byte_w-1:0], byte_data_i};
            end
            MARK: begin
                load_word = out_free;
                next_word = mark_word;
            end
            ZERO: load_word = out_free;
            LEN_HI: begin
                load_word = out_free;
                next_word = bit_len[2*word_bits-1:word_bits];
            end
            LEN_LO: begin
                load_word = out_free;
                next_word = bit_len[word_bits-1:0];
                next_last = 1'b1;
            end
            default: load_word = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= DATA;
            byte_idx     <= '0;
            word_idx     <= '0;
            msg_len      <= '0;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else begin
            if (load_word) begin
                word_valid_o <= 1'b1;
                word_last_o  <= next_last;
                word_idx     <= word_idx + 4'd1;    // wraps at block end
            end else if (word_ready_i) begin
                word_valid_o <= 1'b0;
            end

            case (state)
                DATA: begin
                    if (data_fire) begin
                        byte_idx <= byte_idx + 2'd1;
                        msg_len  <= msg_len + 1'b1;
                    end
                    if (byte_fire && byte_last_i)
                        state <= MARK;
                end
                MARK: if (out_free) begin
                    byte_idx <= '0;
                    state    <= (word_idx == 4'd13) ? LEN_HI : ZERO;
                end
                ZERO: if (out_free && word_idx == 4'd13)
                    state <= LEN_HI;
                LEN_HI: if (out_free)
                    state <= LEN_LO;
                LEN_LO: if (out_free) begin
                    state   <= DATA;
                    msg_len <= '0;
                end
                default: state <= DATA;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_fire)
            acc <= {acc[word_bits-byte_w-1:0], byte_data_i};
        if (load_word)
            word_data_o <= next_word;
    end

endmodule

/* msg_pkg.sv */
// Message framing package
// Byte and length widths and the padder states

package msg_pkg;

    localparam int byte_w = 8;
    localparam int len_w  = 32;    // message length in bytes

    typedef enum logic [2:0] {
        DATA   = 3'h0,
        MARK   = 3'h1,
        ZERO   = 3'h2,
        LEN_HI = 3'h3,
        LEN_LO = 3'h4
    } pad_state_t;

endpackage

/* sha256_assert.sv */
// Handshake and reset assertions for the SHA-256 hasher,
// attached to the top level by bind

`timescale 1ns/1ps

module sha256_assert
    import sha256_pkg::*;
    import msg_pkg::*;
(
    input logic              clk_i,
    input logic              rst_n_i,
    input logic [byte_w-1:0] byte_data_i,
    input logic              byte_last_i,
    input logic              byte_empty_i,
    input logic              byte_valid_i,
    input logic              byte_ready_o,
    input logic [word_w-1:0] digest_data_o,
    input logic              digest_last_o,
    input logic              digest_valid_o,
    input logic              digest_ready_i
);

    int assert_errs = 0;    // failed assertion count

    a_byte_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        byte_valid_i && !byte_ready_o |=>
            byte_valid_i && $stable({byte_data_i, byte_last_i, byte_empty_i}))
        else begin
            $error("byte input changed while waiting for byte_ready_o");
            assert_errs++;
        end

    a_digest_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        digest_valid_o && !digest_ready_i |=>
            digest_valid_o && $stable({digest_data_o, digest_last_o}))
        else begin
            $error("digest output changed while stalled");
            assert_errs++;
        end

    a_reset_values: assert property (@(posedge clk_i)
        !rst_n_i |-> !digest_valid_o && byte_ready_o)
        else begin
            $error("wrong handshake outputs during reset");
            assert_errs++;
        end

endmodule

bind sha256_top sha256_assert u_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .byte_data_i    (byte_data_i),
    .byte_last_i    (byte_last_i),
    .byte_empty_i   (byte_empty_i),
    .byte_valid_i   (byte_valid_i),
    .byte_ready_o   (byte_ready_o),
    .digest_data_o  (digest_data_o),
    .digest_last_o  (digest_last_o),
    .digest_valid_o (digest_valid_o),
    .digest_ready_i (digest_ready_i)
);

/* sha256_checker.sv */
// SHA-256 digest checker
// Software reference hash per message, compares every digest word
// and the last flag at each output transfer

`timescale 1ns/1ps

module sha256_checker
    import sha256_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [word_w-1:0] digest_data_i,
    input  logic              digest_last_i,
    input  logic              digest_valid_i,
    input  logic              digest_ready_i,
    output int                value_errs_o,
    output int                count_errs_o,
    output int                msg_done_o
);

    logic [word_w-1:0] exp_q [$];    // expected words, message order
    logic [word_w-1:0] exp_w;
    int                word_idx;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic [255:0] sha256_ref(input logic [7:0] msg [256], input int len);
        logic [7:0]  blk [256];
        logic [31:0] w [64];
        logic [31:0] hs [8];
        logic [31:0] a, b, c, d, e, f, g, h, t1, t2;
        logic [63:0] bits;
        int          nblk;
        nblk = (len + 8) / 64 + 1;
        bits = 64'(len) << 3;
        for (int i = 0; i < 256; i++)
            blk[i] = (i < len) ? msg[i] : 8'h00;
        blk[len] = 8'h80;
        for (int i = 0; i < 8; i++)
            blk[nblk*64 - 1 - i] = bits[8*i +: 8];    // length big-endian at block end
        hs = hash_iv;
        for (int n = 0; n < nblk; n++) begin
            for (int t = 0; t < 16; t++)
                w[t] = {blk[n*64 + 4*t], blk[n*64 + 4*t + 1],
                        blk[n*64 + 4*t + 2], blk[n*64 + 4*t + 3]};
            for (int t = 16; t < 64; t++)
                w[t] = (rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10)) + w[t-7]
                     + (rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3)) + w[t-16];
            {a, b, c, d, e, f, g, h} = {hs[0], hs[1], hs[2], hs[3], hs[4], hs[5], hs[6], hs[7]};
            for (int t = 0; t < 64; t++) begin
                t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
                   + round_k[t] + w[t];
                t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
                h = g;
                g = f;
                f = e;
                e = d + t1;
                d = c;
                c = b;
                b = a;
                a = t1 + t2;
            end
            hs[0] += a;
            hs[1] += b;
            hs[2] += c;
            hs[3] += d;
            hs[4] += e;
            hs[5] += f;
            hs[6] += g;
            hs[7] += h;
        end
        return {hs[0], hs[1], hs[2], hs[3], hs[4], hs[5], hs[6], hs[7]};
    endfunction

    task automatic add_expected(input logic [7:0] msg [256], input int len);
        logic [255:0] digest;
        digest = sha256_ref(msg, len);
        for (int i = 0; i < 8; i++)
            exp_q.push_back(digest[255 - 32*i -: 32]);
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            value_errs_o = 0;
            count_errs_o = 0;
            msg_done_o   = 0;
            word_idx     = 0;
        end else if (digest_valid_i && digest_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: digest word sent with no message outstanding", $time);
                count_errs_o++;
            end else begin
                exp_w = exp_q.pop_front();
                if (digest_data_i !== exp_w) begin
                    $display("Fail at %0t: digest_data_o word %0d expected %h actual %h",
                             $time, word_idx, exp_w, digest_data_i);
                    value_errs_o++;
                end
            end
            if (digest_last_i !== (word_idx == 7)) begin
                $display("Fail at %0t: digest_last_o word %0d expected %0b actual %0b",
                         $time, word_idx, (word_idx == 7), digest_last_i);
                count_errs_o++;
            end
            if (word_idx == 7) begin
                word_idx = 0;
                msg_done_o++;
            end else begin
                word_idx++;
            end
        end
    end

endmodule

/* sha256_core.sv */
// SHA-256 compression core
// Takes 16 words per block, runs 64 rounds with a rolling schedule
// window, chains the blocks of a message and sends the digest a to h

`timescale 1ns/1ps

module sha256_core
    import sha256_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [word_w-1:0] in_data_i,
    input  logic              in_last_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output logic [word_w-1:0] digest_data_o,
    output logic              digest_last_o,
    output logic              digest_valid_o,
    input  logic              digest_ready_i
);

    core_state_t       state;
    logic [5:0]        rnd;
    logic [2:0]        out_cnt;
    logic              blk_last;    // current block holds the last word

    logic [word_w-1:0] a, b, c, d, e, f, g, h;
    logic [word_w-1:0] hv [8];      // chaining value, digest at the end
    logic [word_w-1:0] blk_sum [8];
    logic [word_w-1:0] win [16];    // W[t-16] .. W[t-1]

    logic              in_phase;
    logic              step;
    logic [word_w-1:0] w_sched;
    logic [word_w-1:0] w_t;
    logic [word_w-1:0] sig0, sig1;
    logic [word_w-1:0] bsig0, bsig1;
    logic [word_w-1:0] ch, maj;
    logic [word_w-1:0] t1, t2;

    function automatic logic [word_w-1:0] rotr(input logic [word_w-1:0] x, input int n);
        return (x >> n) | (x << (word_w - n));
    endfunction

    assign in_phase   = (rnd[5:4] == 2'b00);    // rounds 0 to 15
    assign in_ready_o = (state == NEXT) && in_phase;
    assign step       = (state == NEXT) && (!in_phase || in_valid_i);

    assign sig0    = rotr(win[1], 7) ^ rotr(win[1], 18) ^ (win[1] >> 3);
    assign sig1    = rotr(win[14], 17) ^ rotr(win[14], 19) ^ (win[14] >> 10);
    assign w_sched = sig1 + win[9] + sig0 + win[0];
    assign w_t     = in_phase ? in_data_i : w_sched;

    assign bsig0 = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
    assign bsig1 = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);
    assign ch    = (e & f) ^ (~e & g);
    assign maj   = (a & b) ^ (a & c) ^ (b & c);
    assign t1    = h + bsig1 + ch + round_k[rnd] + w_t;
    assign t2    = bsig0 + maj;

    always_comb begin
        blk_sum[0] = hv[0] + a;
        blk_sum[1] = hv[1] + b;
        blk_sum[2] = hv[2] + c;
        blk_sum[3] = hv[3] + d;
        blk_sum[4] = hv[4] + e;
        blk_sum[5] = hv[5] + f;
        blk_sum[6] = hv[6] + g;
        blk_sum[7] = hv[7] + h;
    end

    assign digest_valid_o = (state == LAST);
    assign digest_last_o  = (state == LAST) && (out_cnt == 3'd7);
    assign digest_data_o  = hv[out_cnt];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            rnd      <= '0;
            out_cnt  <= '0;
            blk_last <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    rnd      <= '0;
                    out_cnt  <= '0;
                    blk_last <= 1'b0;
                    state    <= NEXT;
                end
                NEXT: if (step) begin
                    rnd <= rnd + 6'd1;                 // wraps to 0 after round 63
                    if (in_phase && in_last_i)
                        blk_last <= 1'b1;
                    if (rnd == 6'd63)
                        state <= LOAD;
                end
                LOAD: state <= blk_last ? LAST : NEXT;
                LAST: if (digest_ready_i) begin
                    out_cnt <= out_cnt + 3'd1;
                    if (out_cnt == 3'd7)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state)
            IDLE: begin
                hv <= hash_iv;
                {a, b, c, d, e, f, g, h} <= {hash_iv[0], hash_iv[1], hash_iv[2], hash_iv[3],
                                             hash_iv[4], hash_iv[5], hash_iv[6], hash_iv[7]};
            end
            NEXT: if (step) begin
                a <= t1 + t2;
                b <= a;
                c <= b;
                d <= c;
                e <= d + t1;
                f <= e;
                g <= f;
                h <= g;
                for (int j = 0; j < 15; j++)
                    win[j] <= win[j+1];
                win[15] <= w_t;
            end
            LOAD: begin
                hv <= blk_sum;    // also the next block's start value
                {a, b, c, d, e, f, g, h} <= {blk_sum[0], blk_sum[1], blk_sum[2], blk_sum[3],
                                             blk_sum[4], blk_sum[5], blk_sum[6], blk_sum[7]};
            end
            default: ;
        endcase
    end

endmodule

/* sha256_pkg.sv */
// SHA-256 algorithm package
// Round constants, initial hash values, the word width
// and the controller states of the compression core

package sha256_pkg;

    localparam int word_w = 32;

    localparam logic [word_w-1:0] round_k [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // a first, h last
    localparam logic [word_w-1:0] hash_iv [8] = '{
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    typedef enum logic [1:0] {
        IDLE = 2'h0,    // restart from hash_iv
        LOAD = 2'h1,    // chaining add
        NEXT = 2'h2,    // rounds
        LAST = 2'h3     // digest output
    } core_state_t;

endpackage

/* sha256_top.sv */
// SHA-256 streaming hasher
// Byte stream in, padder into word FIFO into compression core,
// eight digest words out

`timescale 1ns/1ps

module sha256_top
    import sha256_pkg::*;
    import msg_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [byte_w-1:0] byte_data_i,
    input  logic              byte_last_i,
    input  logic              byte_empty_i,
    input  logic              byte_valid_i,
    output logic              byte_ready_o,
    output logic [word_w-1:0] digest_data_o,
    output logic              digest_last_o,
    output logic              digest_valid_o,
    input  logic              digest_ready_i
);

    logic [word_w-1:0] pad_data;
    logic              pad_last;
    logic              pad_valid;
    logic              pad_ready;

    logic [word_w-1:0] fifo_data;
    logic              fifo_last;
    logic              fifo_valid;
    logic              fifo_ready;

    msg_padder u_padder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .byte_data_i  (byte_data_i),
        .byte_last_i  (byte_last_i),
        .byte_empty_i (byte_empty_i),
        .byte_valid_i (byte_valid_i),
        .byte_ready_o (byte_ready_o),
        .word_data_o  (pad_data),
        .word_last_o  (pad_last),
        .word_valid_o (pad_valid),
        .word_ready_i (pad_ready)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_data_i  (pad_data),
        .wr_last_i  (pad_last),
        .wr_valid_i (pad_valid),
        .wr_ready_o (pad_ready),
        .rd_data_o  (fifo_data),
        .rd_last_o  (fifo_last),
        .rd_valid_o (fifo_valid),
        .rd_ready_i (fifo_ready)
    );

    sha256_core u_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_data_i      (fifo_data),
        .in_last_i      (fifo_last),
        .in_valid_i     (fifo_valid),
        .in_ready_o     (fifo_ready),
        .digest_data_o  (digest_data_o),
        .digest_last_o  (digest_last_o),
        .digest_valid_o (digest_valid_o),
        .digest_ready_i (digest_ready_i)
    );

endmodule

/* tb_sha256.sv */
// SHA-256 hasher testbench
// Fixed, boundary and random messages on the byte port, random
// stalls on the digest port, summary of the checker counts

`timescale 1ns/1ps

module tb_sha256
    import sha256_pkg::*;
    import msg_pkg::*;
();

    localparam int byte_timeout  = 2000;
    localparam int drain_timeout = 8000;

    logic              clk_i;
    logic              rst_n_i;
    logic [byte_w-1:0] byte_data_i;
    logic              byte_last_i;
    logic              byte_empty_i;
    logic              byte_valid_i;
    logic              byte_ready_o;
    logic [word_w-1:0] digest_data_o;
    logic              digest_last_o;
    logic              digest_valid_o;
    logic              digest_ready_i;

    logic [7:0]  msg [256];
    logic [31:0] lfsr_q = 32'h85d8b0c0;
    int          msgs_sent;
    int          timeouts;
    int          value_errs;
    int          count_errs;
    int          msg_done;

    sha256_top #(.FIFO_DEPTH(16)) u_dut (.*);

    sha256_checker u_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .digest_data_i  (digest_data_o),
        .digest_last_i  (digest_last_o),
        .digest_valid_i (digest_valid_o),
        .digest_ready_i (digest_ready_i),
        .value_errs_o   (value_errs),
        .count_errs_o   (count_errs),
        .msg_done_o     (msg_done)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];    // x^32+x^22+x^2+x+1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
            val = {val[30:0], lfsr_step()};
        return val;
    endfunction

    // every tb wait steps through here and draws one digest stall
    task automatic next_cycle();
        @(negedge clk_i);
        digest_ready_i = (rand_bits(2) != 32'd0);
    endtask

    task automatic fill_random(input int len);
        for (int i = 0; i < len; i++)
            msg[i] = 8'(rand_bits(8));
    endtask

    task automatic send_byte(input logic [7:0] data, input logic last, input logic empty);
        int waited;
        byte_data_i  = data;
        byte_last_i  = last;
        byte_empty_i = empty;
        byte_valid_i = 1'b1;
        waited = 0;
        while (!byte_ready_o && waited < byte_timeout) begin
            next_cycle();
            waited++;
        end
        if (byte_ready_o) begin
            next_cycle();    // transfer on the rising edge in between
        end else begin
            $display("Timeout at %0t: byte not accepted within %0d cycles", $time, byte_timeout);
            timeouts++;
        end
    endtask

    task automatic send_msg(input int len, input logic gaps);
        if (timeouts == 0) begin
            u_checker.add_expected(msg, len);
            msgs_sent++;
            if (len == 0)
                send_byte(8'h00, 1'b1, 1'b1);
            for (int i = 0; i < len && timeouts == 0; i++) begin
                send_byte(msg[i], (i == len - 1), 1'b0);
                if (gaps && rand_bits(2) == 32'd0) begin
                    byte_valid_i = 1'b0;
                    repeat (int'(rand_bits(2)) + 1) next_cycle();
                end
            end
            byte_valid_i = 1'b0;
        end
    endtask

    initial begin
        int lens [5];
        int waited;
        lens           = '{55, 56, 63, 64, 119};
        rst_n_i        = 1'b0;
        byte_data_i    = '0;
        byte_last_i    = 1'b0;
        byte_empty_i   = 1'b0;
        byte_valid_i   = 1'b0;
        digest_ready_i = 1'b0;
        msgs_sent      = 0;
        timeouts       = 0;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        next_cycle();

        send_msg(0, 1'b0);
        msg[0] = 8'h61;    // "abc"
        msg[1] = 8'h62;
        msg[2] = 8'h63;
        send_msg(3, 1'b0);
        foreach (lens[i]) begin
            fill_random(lens[i]);
            send_msg(lens[i], 1'b0);
        end
        for (int m = 0; m < 24; m++) begin
            waited = int'(rand_bits(8)) % 201;    // length up to 200
            fill_random(waited);
            send_msg(waited, 1'b1);
        end

        waited = 0;
        while (timeouts == 0 && msg_done < msgs_sent && waited < drain_timeout) begin
            next_cycle();
            waited++;
        end
        if (timeouts == 0 && msg_done < msgs_sent) begin
            $display("Timeout at %0t: only %0d of %0d digests came out",
                     $time, msg_done, msgs_sent);
            timeouts++;
        end
        repeat (20) next_cycle();    // room for stray extra words

        $display("Summary: %0d messages, errors %0d value %0d count %0d assertion, %0d timeouts",
                 msgs_sent, value_errs, count_errs, u_dut.u_assert.assert_errs, timeouts);
        if (value_errs + count_errs + u_dut.u_assert.assert_errs + timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* word_fifo.sv */
// Message word FIFO
// Circular buffer of data words with their last flag,
// decouples the padder from the compression core

`timescale 1ns/1ps

module word_fifo
    import sha256_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [word_w-1:0] wr_data_i,
    input  logic              wr_last_i,
    input  logic              wr_valid_i,
    output logic              wr_ready_o,
    output logic [word_w-1:0] rd_data_o,
    output logic              rd_last_o,
    output logic              rd_valid_o,
    input  logic              rd_ready_i
);

    localparam int aw = $clog2(FIFO_DEPTH);

    logic [word_w:0] mem [FIFO_DEPTH];    // {last, data}
    logic [aw:0]     wr_ptr;              // msb is the wrap bit
    logic [aw:0]     rd_ptr;
    logic            wr_fire;
    logic            rd_fire;

    assign wr_ready_o = !((wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]));
    assign rd_valid_o = (wr_ptr != rd_ptr);
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    assign {rd_last_o, rd_data_o} = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire)
            mem[wr_ptr[aw-1:0]] <= {wr_last_i, wr_data_i};
    end

endmodule
